// File: src/qv_isa_pkg.sv
`default_nettype none

package qv_isa_pkg;

    // Function field of the ALU view
    // Compare functions always subtract, so only this one needs naming
    localparam logic [2:0] FN_CMP = 3'b010;

    // Bit 3 is the flag: subtract for add/sub, signed for the compares
    localparam logic [3:0] ALU_ADD  = 4'b0000;
    localparam logic [3:0] ALU_SUB  = 4'b1000;
    localparam logic [3:0] ALU_SLT  = 4'b1010;
    localparam logic [3:0] ALU_SLTU = 4'b0010;
    localparam logic [3:0] ALU_XOR  = 4'b0100;
    localparam logic [3:0] ALU_OR   = 4'b0110;
    localparam logic [3:0] ALU_AND  = 4'b0111;

    // CSR operation kind, taken from funct3[1:0]
    localparam logic [1:0] CSR_NONE = 2'b00;
    localparam logic [1:0] CSR_RW   = 2'b01;
    localparam logic [1:0] CSR_RS   = 2'b10;
    localparam logic [1:0] CSR_RC   = 2'b11;

    // Branch conditions as carried on mem_op (funct3)
    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

    // Read-only counter CSRs
    localparam logic [11:0] CSR_CYCLE   = 12'hC00;
    localparam logic [11:0] CSR_INSTRET = 12'hC02;

    // Normal decode of alu_op
    typedef struct packed {
        logic       flag;  // Subtract, or signed compare
        logic [2:0] func;
    } alu_fields_t;

    // Decode of alu_op when is_system is set
    typedef struct packed {
        logic [1:0] rsvd;
        logic [1:0] kind;  // CSR_RW / CSR_RS / CSR_RC, or CSR_NONE
    } csr_fields_t;

    typedef union packed {
        alu_fields_t alu;
        csr_fields_t csr;
    } alu_op_u;

endpackage

`default_nettype wire

// File: src/qv_timing_pkg.sv
`default_nettype none

package qv_timing_pkg;

    // Datapath width per clock
    localparam int NIBBLE_BITS = 4;

    // Sub-cycle counter, one count per nibble
    localparam int COUNT_BITS = 3;

    // Count of the top nibble of a word
    localparam int LAST_COUNT = 7;

endpackage

`default_nettype wire

// File: src/tinyqv_alu.sv
`timescale 1ns/100ps
`default_nettype none

module tinyqv_alu (
    input  qv_isa_pkg::alu_op_u                  op,
    input  logic [qv_timing_pkg::NIBBLE_BITS-1:0] a,
    input  logic [qv_timing_pkg::NIBBLE_BITS-1:0] b,
    input  logic                                  cy_in,
    input  logic                                  cmp_in,
    output logic [qv_timing_pkg::NIBBLE_BITS-1:0] result,
    output logic                                  cy_out,
    output logic                                  cmp_out
);

    localparam int NB = qv_timing_pkg::NIBBLE_BITS;

    logic          subtract;
    logic [NB-1:0] b_in;
    logic [NB:0]   sum;
    logic          lt_signed;
    logic          lt_unsigned;

    assign subtract = op.alu.flag || (op.alu.func == qv_isa_pkg::FN_CMP);
    assign b_in     = subtract ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_in} + {{NB{1'b0}}, cy_in};
    assign cy_out   = sum[NB];

    // Only meaningful on the top nibble
    assign lt_signed   = (a[NB-1] ^ b[NB-1]) ? a[NB-1] : sum[NB-1];
    assign lt_unsigned = ~sum[NB];  // No carry out means a borrow

    always_comb begin
        result  = sum[NB-1:0];
        cmp_out = cmp_in && (a == b);  // Equality chain by default
        case (op)
            qv_isa_pkg::ALU_ADD,
            qv_isa_pkg::ALU_SUB: result = sum[NB-1:0];
            qv_isa_pkg::ALU_SLT,
            qv_isa_pkg::ALU_SLTU: begin
                cmp_out = op.alu.flag ? lt_signed : lt_unsigned;
            end
            qv_isa_pkg::ALU_XOR: result = a ^ b;
            qv_isa_pkg::ALU_OR:  result = a | b;
            qv_isa_pkg::ALU_AND: result = a & b;
            default: result = sum[NB-1:0];
        endcase
    end

endmodule

`default_nettype wire

// File: src/tinyqv_registers.sv
`timescale 1ns/100ps
`default_nettype none

module tinyqv_registers #(
    parameter int NUM_REGS      = 16,
    parameter int REG_ADDR_BITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  wr_en,
    input  logic [qv_timing_pkg::COUNT_BITS-1:0]  counter,
    input  logic [REG_ADDR_BITS-1:0]              rs1,
    input  logic [REG_ADDR_BITS-1:0]              rs2,
    input  logic [REG_ADDR_BITS-1:0]              rd,
    input  logic [qv_timing_pkg::NIBBLE_BITS-1:0] data_rd,
    output logic [qv_timing_pkg::NIBBLE_BITS-1:0] data_rs1,
    output logic [qv_timing_pkg::NIBBLE_BITS-1:0] data_rs2
);

    localparam int NB        = qv_timing_pkg::NIBBLE_BITS;
    localparam int WORD_BITS = NB * (qv_timing_pkg::LAST_COUNT + 1);

    // x0 has no storage
    logic [WORD_BITS-1:0] regs [1:NUM_REGS-1];

    // Every register rotates right one nibble per clock, so the nibble
    // at the bottom always lines up with the current count
    always_ff @(posedge clk) begin
        for (int i = 1; i < NUM_REGS; i++) begin
            if (wr_en && (rd == i)) begin
                regs[i] <= {data_rd, regs[i][WORD_BITS-1:NB]};
            end else begin
                regs[i] <= {regs[i][NB-1:0], regs[i][WORD_BITS-1:NB]};
            end
        end
    end

    assign data_rs1 = (rs1 == '0) ? '0 : regs[rs1][NB-1:0];
    assign data_rs2 = (rs2 == '0) ? '0 : regs[rs2][NB-1:0];

    // rd must exist, and may only change at a word boundary while writing
    wr_addr_ok: assert property (
        @(posedge clk) disable iff (!rstn)
        wr_en |-> (rd < NUM_REGS) && ((counter == '0) || $stable(rd))
    ) else $error("bad register write: rd %0d at count %0d", rd, counter);

endmodule

`default_nettype wire

// File: src/tinyqv_counter.sv
`timescale 1ns/100ps
`default_nettype none

module tinyqv_counter (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  add,
    input  logic [qv_timing_pkg::COUNT_BITS-1:0]  counter,
    output logic [qv_timing_pkg::NIBBLE_BITS-1:0] data,
    output logic                                  cy_out
);

    localparam int NB        = qv_timing_pkg::NIBBLE_BITS;
    localparam int WORD_BITS = NB * (qv_timing_pkg::LAST_COUNT + 1);

    logic [WORD_BITS-1:0] value;
    logic                 cy;
    logic                 carry_in;
    logic [NB:0]          sum;

    // Strobe enters at the low nibble, then the carry ripples up
    assign carry_in = (counter == '0) ? add : cy;
    assign sum      = {1'b0, value[NB-1:0]} + {{NB{1'b0}}, carry_in};
    assign data     = sum[NB-1:0];  // Value including this word's add
    assign cy_out   = sum[NB];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            value <= '0;
            cy    <= 1'b0;
        end else begin
            value <= {sum[NB-1:0], value[WORD_BITS-1:NB]};
            cy    <= sum[NB];
        end
    end

endmodule

`default_nettype wire

// File: src/tinyqv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tinyqv_core #(
    parameter int NUM_REGS      = 16,
    parameter int REG_ADDR_BITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic [qv_timing_pkg::COUNT_BITS-1:0]  counter,

    input  logic [qv_timing_pkg::NIBBLE_BITS-1:0] imm,
    input  logic [11:0]                           imm_lo,

    input  logic                                  is_alu_imm,
    input  logic                                  is_alu_reg,
    input  logic                                  is_lui,
    input  logic                                  is_branch,
    input  logic                                  is_system,

    input  qv_isa_pkg::alu_op_u                   alu_op,
    input  logic [2:0]                            mem_op,

    input  logic [REG_ADDR_BITS-1:0]              rs1,
    input  logic [REG_ADDR_BITS-1:0]              rs2,
    input  logic [REG_ADDR_BITS-1:0]              rd,

    output logic                                  instr_complete,
    output logic                                  branch,
    output logic                                  debug_reg_wen,
    output logic [qv_timing_pkg::NIBBLE_BITS-1:0] debug_rd
);

    localparam int NB = qv_timing_pkg::NIBBLE_BITS;

    logic          last_count;
    logic          is_alu;
    logic          is_slt;
    logic          is_csr;
    logic          second_word;  // slt/sltu writing its result

    assign last_count = (counter == qv_timing_pkg::LAST_COUNT);
    assign is_alu     = is_alu_imm || is_alu_reg;
    assign is_slt     = (alu_op.alu.func == qv_isa_pkg::FN_CMP);
    assign is_csr     = is_system && (alu_op.csr.kind != qv_isa_pkg::CSR_NONE);

    logic [NB-1:0] data_rs1;
    logic [NB-1:0] data_rs2;
    logic [NB-1:0] data_rd;
    logic          wr_en;

    tinyqv_registers #(
        .NUM_REGS      (NUM_REGS),
        .REG_ADDR_BITS (REG_ADDR_BITS)
    ) i_registers (
        .clk      (clk),
        .rstn     (rstn),
        .wr_en    (wr_en),
        .counter  (counter),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .data_rd  (data_rd),
        .data_rs1 (data_rs1),
        .data_rs2 (data_rs2)
    );

    // Branches borrow the ALU compare
    qv_isa_pkg::alu_op_u alu_in;
    logic                invert_cond;

    always_comb begin
        alu_in = alu_op;
        if (is_branch) begin
            case (mem_op)
                qv_isa_pkg::BR_EQ,
                qv_isa_pkg::BR_NE:  alu_in = qv_isa_pkg::ALU_SUB;
                qv_isa_pkg::BR_LT,
                qv_isa_pkg::BR_GE:  alu_in = qv_isa_pkg::ALU_SLT;
                default:            alu_in = qv_isa_pkg::ALU_SLTU;
            endcase
        end
    end

    assign invert_cond = (mem_op == qv_isa_pkg::BR_NE) || (mem_op == qv_isa_pkg::BR_GE) ||
                         (mem_op == qv_isa_pkg::BR_GEU);

    logic [NB-1:0] alu_b;
    logic [NB-1:0] alu_out;
    logic          cy;
    logic          cmp;
    logic          cy_in;
    logic          cmp_in;
    logic          cy_out;
    logic          cmp_out;

    assign alu_b  = (is_alu_reg || is_branch) ? data_rs2 : imm;
    assign cy_in  = (counter == '0) ? (alu_in.alu.flag || (alu_in.alu.func == qv_isa_pkg::FN_CMP))
                                    : cy;
    assign cmp_in = (counter == '0) ? 1'b1 : cmp;

    tinyqv_alu i_alu (
        .op      (alu_in),
        .a       (data_rs1),
        .b       (alu_b),
        .cy_in   (cy_in),
        .cmp_in  (cmp_in),
        .result  (alu_out),
        .cy_out  (cy_out),
        .cmp_out (cmp_out)
    );

    always_ff @(posedge clk) begin
        cy  <= cy_out;
        cmp <= cmp_out;  // Holds the final compare at count 0 of the next word
    end

    // Counter CSRs, each read includes everything up to the previous word
    logic          cycle_add;
    logic          retired;
    logic [NB-1:0] cycle_data;
    logic [NB-1:0] instret_data;
    logic [NB-1:0] csr_read;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycle_add <= 1'b0;
            retired   <= 1'b0;
        end else if (last_count) begin
            cycle_add <= 1'b1;  // Word 0 reads zero
            retired   <= instr_complete;
        end
    end

    tinyqv_counter i_cycle (
        .clk     (clk),
        .rstn    (rstn),
        .add     (cycle_add),
        .counter (counter),
        .data    (cycle_data),
        .cy_out  ()
    );

    tinyqv_counter i_instret (
        .clk     (clk),
        .rstn    (rstn),
        .add     (retired),
        .counter (counter),
        .data    (instret_data),
        .cy_out  ()
    );

    always_comb begin
        case (imm_lo)
            qv_isa_pkg::CSR_CYCLE:   csr_read = cycle_data;
            qv_isa_pkg::CSR_INSTRET: csr_read = instret_data;
            default:                 csr_read = '0;
        endcase
    end

    // Writeback
    always_comb begin
        wr_en   = 1'b0;
        data_rd = '0;
        if (is_alu) begin
            if (is_slt) begin
                wr_en   = second_word;  // First word only resolves the compare
                data_rd = (counter == '0) ? {{(NB-1){1'b0}}, cmp} : '0;
            end else begin
                wr_en   = 1'b1;
                data_rd = alu_out;
            end
        end else if (is_lui) begin
            wr_en   = 1'b1;
            data_rd = imm;
        end else if (is_csr) begin
            wr_en   = 1'b1;
            data_rd = csr_read;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            second_word <= 1'b0;
        end else if (last_count) begin
            second_word <= is_alu && is_slt && !second_word;
        end
    end

    assign instr_complete = last_count &&
                            (is_lui || is_branch || is_system ||
                             (is_alu && (!is_slt || second_word)));
    assign branch         = last_count && is_branch && (cmp_out ^ invert_cond);

    assign debug_reg_wen = wr_en;
    assign debug_rd      = data_rd;

    // Completion lines up with the word wrap of the top level counter
    complete_at_wrap: assert property (
        @(posedge clk) disable iff (!rstn)
        instr_complete |=> (counter == '0)
    ) else $error("instr_complete not followed by a word wrap");

    // A taken branch never writes a register
    branch_without_write: assert property (
        @(posedge clk) disable iff (!rstn)
        branch |-> !wr_en
    ) else $error("branch pulse while writing a register");

endmodule

`default_nettype wire

// File: src/tinyqv_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module tinyqv_exec_top #(
    parameter int NUM_REGS      = 16,
    parameter int REG_ADDR_BITS = 4
) (
    input  logic                                  clk,
    input  logic                                  rstn,

    input  logic [qv_timing_pkg::NIBBLE_BITS-1:0] imm,  // Nibble for the current count
    input  logic [11:0]                           imm_lo,

    input  logic                                  is_alu_imm,
    input  logic                                  is_alu_reg,
    input  logic                                  is_lui,
    input  logic                                  is_branch,
    input  logic                                  is_system,

    input  qv_isa_pkg::alu_op_u                   alu_op,
    input  logic [2:0]                            mem_op,

    input  logic [REG_ADDR_BITS-1:0]              rs1,
    input  logic [REG_ADDR_BITS-1:0]              rs2,
    input  logic [REG_ADDR_BITS-1:0]              rd,

    output logic                                  instr_complete,
    output logic                                  branch,
    output logic                                  debug_reg_wen,
    output logic [qv_timing_pkg::NIBBLE_BITS-1:0] debug_rd
);

    // Sub-cycle counter, one step per nibble
    logic [qv_timing_pkg::COUNT_BITS-1:0] counter;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            counter <= '0;
        end else if (counter == qv_timing_pkg::LAST_COUNT) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    tinyqv_core #(
        .NUM_REGS      (NUM_REGS),
        .REG_ADDR_BITS (REG_ADDR_BITS)
    ) i_core (
        .clk            (clk),
        .rstn           (rstn),
        .counter        (counter),
        .imm            (imm),
        .imm_lo         (imm_lo),
        .is_alu_imm     (is_alu_imm),
        .is_alu_reg     (is_alu_reg),
        .is_lui         (is_lui),
        .is_branch      (is_branch),
        .is_system      (is_system),
        .alu_op         (alu_op),
        .mem_op         (mem_op),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .instr_complete (instr_complete),
        .branch         (branch),
        .debug_reg_wen  (debug_reg_wen),
        .debug_rd       (debug_rd)
    );

endmodule

`default_nettype wire

// File: bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Architectural state the bench expects
logic [31:0] model_regs [NUM_REGS];
int unsigned word_count;     // Whole words since reset
int unsigned retired_count;  // Completions in earlier words

function automatic logic [31:0] reg_value(input logic [REG_ADDR_BITS-1:0] idx);
    return (idx == '0) ? 32'h0 : model_regs[idx];  // x0 is hardwired
endfunction

function automatic logic [31:0] alu_result(input qv_isa_pkg::alu_op_u fn,
                                           input logic [31:0] a,
                                           input logic [31:0] b);
    case (fn)
        qv_isa_pkg::ALU_ADD:  return a + b;
        qv_isa_pkg::ALU_SUB:  return a - b;
        qv_isa_pkg::ALU_XOR:  return a ^ b;
        qv_isa_pkg::ALU_OR:   return a | b;
        qv_isa_pkg::ALU_AND:  return a & b;
        qv_isa_pkg::ALU_SLT:  return {31'b0, ($signed(a) < $signed(b))};
        qv_isa_pkg::ALU_SLTU: return {31'b0, (a < b)};
        default:              return 32'h0;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] cc,
                                      input logic [31:0] a,
                                      input logic [31:0] b);
    case (cc)
        qv_isa_pkg::BR_EQ:  return a == b;
        qv_isa_pkg::BR_NE:  return a != b;
        qv_isa_pkg::BR_LT:  return $signed(a) < $signed(b);
        qv_isa_pkg::BR_GE:  return $signed(a) >= $signed(b);
        qv_isa_pkg::BR_LTU: return a < b;
        default:            return a >= b;  // BR_GEU
    endcase
endfunction

// Value a CSR read returns in the current word
function automatic logic [31:0] csr_value(input logic [11:0] addr);
    return (addr == qv_isa_pkg::CSR_CYCLE) ? word_count : retired_count;
endfunction

task automatic check_nibble(input string name,
                            input logic [qv_timing_pkg::NIBBLE_BITS-1:0] got,
                            input logic [qv_timing_pkg::NIBBLE_BITS-1:0] exp);
    if (got !== exp) begin
        $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        abort_run();
    end
endtask

`endif

// File: bench/tb_exec_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_exec_top;

    localparam int NUM_REGS      = 16;
    localparam int REG_ADDR_BITS = 4;
    localparam int NB            = qv_timing_pkg::NIBBLE_BITS;
    localparam int LAST          = qv_timing_pkg::LAST_COUNT;
    localparam int WORD_CLKS     = qv_timing_pkg::LAST_COUNT + 1;
    localparam int NUM_INSTRS    = 400;
    localparam int CLK_NS        = 8;
    localparam int RESET_CYCLES  = 5;
    localparam int MARGIN_NS     = (RESET_CYCLES + 4 * WORD_CLKS) * CLK_NS;
    localparam int WATCHDOG_NS   = NUM_INSTRS * 2 * WORD_CLKS * CLK_NS + MARGIN_NS;

    // Instruction kinds
    localparam int K_IDLE    = 0;
    localparam int K_ALU_REG = 1;
    localparam int K_ALU_IMM = 2;
    localparam int K_LUI     = 3;
    localparam int K_BRANCH  = 4;
    localparam int K_CSR     = 5;

    localparam logic [3:0] ALU_OPS [7] = '{qv_isa_pkg::ALU_ADD, qv_isa_pkg::ALU_SUB,
        qv_isa_pkg::ALU_SLT, qv_isa_pkg::ALU_SLTU, qv_isa_pkg::ALU_XOR,
        qv_isa_pkg::ALU_OR, qv_isa_pkg::ALU_AND};
    localparam logic [2:0] BR_CONDS [6] = '{qv_isa_pkg::BR_EQ, qv_isa_pkg::BR_NE,
        qv_isa_pkg::BR_LT, qv_isa_pkg::BR_GE, qv_isa_pkg::BR_LTU, qv_isa_pkg::BR_GEU};

    logic                     clk;
    logic                     rstn;
    logic [NB-1:0]            imm;
    logic [11:0]              imm_lo;
    logic                     is_alu_imm;
    logic                     is_alu_reg;
    logic                     is_lui;
    logic                     is_branch;
    logic                     is_system;
    qv_isa_pkg::alu_op_u      alu_op;
    logic [2:0]               mem_op;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rd;
    logic                     instr_complete;
    logic                     branch;
    logic                     debug_reg_wen;
    logic [NB-1:0]            debug_rd;

    tinyqv_exec_top #(
        .NUM_REGS      (NUM_REGS),
        .REG_ADDR_BITS (REG_ADDR_BITS)
    ) uut (
        .clk            (clk),
        .rstn           (rstn),
        .imm            (imm),
        .imm_lo         (imm_lo),
        .is_alu_imm     (is_alu_imm),
        .is_alu_reg     (is_alu_reg),
        .is_lui         (is_lui),
        .is_branch      (is_branch),
        .is_system      (is_system),
        .alu_op         (alu_op),
        .mem_op         (mem_op),
        .rs1            (rs1),
        .rs2            (rs2),
        .rd             (rd),
        .instr_complete (instr_complete),
        .branch         (branch),
        .debug_reg_wen  (debug_reg_wen),
        .debug_rd       (debug_rd)
    );

    // Current instruction
    int                       kind;
    qv_isa_pkg::alu_op_u      op;
    logic [2:0]               cond;
    logic [REG_ADDR_BITS-1:0] src1;
    logic [REG_ADDR_BITS-1:0] src2;
    logic [REG_ADDR_BITS-1:0] dst;
    logic [31:0]              imm_word;
    logic [11:0]              csr_addr;

    `include "tb_model.svh"

    always #(CLK_NS / 2) clk = ~clk;

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic pick_instr(input int n);
        if (n < NUM_REGS - 1) begin
            kind = K_LUI;  // Give every register a known value first
            dst  = n + 1;
        end else begin
            kind = 1 + ($urandom % 5);
            dst  = $urandom % NUM_REGS;
        end
        op       = ALU_OPS[$urandom % 7];
        cond     = BR_CONDS[$urandom % 6];
        src1     = $urandom % NUM_REGS;
        src2     = ($urandom % 4 == 0) ? src1 : REG_ADDR_BITS'($urandom % NUM_REGS);
        imm_word = $urandom;
        csr_addr = ($urandom % 2) ? qv_isa_pkg::CSR_CYCLE : qv_isa_pkg::CSR_INSTRET;
        if (kind == K_CSR) begin
            op.csr.rsvd = 2'b00;
            op.csr.kind = qv_isa_pkg::CSR_RS;  // csrrs rd, csr, x0
            src1        = '0;
        end
    endtask

    task automatic drive_inputs(input int c);
        rstn       <= 1'b1;  // First driven nibble ends reset
        is_alu_reg <= (kind == K_ALU_REG);
        is_alu_imm <= (kind == K_ALU_IMM);
        is_lui     <= (kind == K_LUI);
        is_branch  <= (kind == K_BRANCH);
        is_system  <= (kind == K_CSR);
        alu_op     <= op;
        mem_op     <= cond;
        rs1        <= src1;
        rs2        <= src2;
        rd         <= dst;
        imm        <= imm_word[c*NB +: NB];
        imm_lo     <= (kind == K_CSR) ? csr_addr : imm_word[11:0];
    endtask

    task automatic run_instr();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic        writes;
        logic        two_words;
        logic        taken;
        logic        exp_wen;
        a         = reg_value(src1);
        b         = (kind == K_ALU_IMM) ? imm_word : reg_value(src2);
        two_words = (kind == K_ALU_REG || kind == K_ALU_IMM) &&
                    (op == qv_isa_pkg::ALU_SLT || op == qv_isa_pkg::ALU_SLTU);
        writes    = 1'b1;
        taken     = 1'b0;
        case (kind)
            K_ALU_REG, K_ALU_IMM: result = alu_result(op, a, b);
            K_LUI:                result = imm_word;
            K_CSR:                result = csr_value(csr_addr);
            K_BRANCH: begin
                result = '0;
                writes = 1'b0;
                taken  = branch_taken(cond, a, b);
            end
            default: begin
                result = '0;
                writes = 1'b0;
            end
        endcase
        for (int w = 0; w < (two_words ? 2 : 1); w++) begin
            for (int c = 0; c < WORD_CLKS; c++) begin
                @(posedge clk);
                drive_inputs(c);
                @(negedge clk);  // Outputs settled mid-cycle
                exp_wen = writes && (!two_words || w == 1);
                check_flag("debug_reg_wen", debug_reg_wen, exp_wen);
                if (exp_wen) begin
                    check_nibble("debug_rd", debug_rd, result[c*NB +: NB]);
                end
                check_flag("instr_complete", instr_complete,
                           (c == LAST) && (kind != K_IDLE) && (!two_words || w == 1));
                check_flag("branch", branch, (c == LAST) && taken);
            end
            word_count++;
        end
        if (kind != K_IDLE) begin
            retired_count++;
        end
        if (writes && dst != '0) begin
            model_regs[dst] = result;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: instruction stream still running after %0d ns", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        imm           = '0;
        imm_lo        = '0;
        is_alu_imm    = 1'b0;
        is_alu_reg    = 1'b0;
        is_lui        = 1'b0;
        is_branch     = 1'b1;  // A taken beq x0, x0 held through reset
        is_system     = 1'b0;
        alu_op        = '0;
        mem_op        = '0;
        rs1           = '0;
        rs2           = '0;
        rd            = '0;
        kind          = K_IDLE;
        op            = '0;
        cond          = '0;
        src1          = '0;
        src2          = '0;
        dst           = '0;
        imm_word      = '0;
        csr_addr      = '0;
        word_count    = 0;
        retired_count = 0;
        void'($urandom(32'h1dd785f5));

        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_flag("instr_complete", instr_complete, 1'b0);
            check_flag("branch", branch, 1'b0);
            check_flag("debug_reg_wen", debug_reg_wen, 1'b0);
        end

        run_instr();  // Idle word 0
        for (int n = 0; n < NUM_INSTRS; n++) begin
            pick_instr(n);
            run_instr();
        end

        $display("%0d instructions over %0d words matched the model", NUM_INSTRS, word_count);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+bench
src/qv_isa_pkg.sv
src/qv_timing_pkg.sv
src/tinyqv_alu.sv
src/tinyqv_registers.sv
src/tinyqv_counter.sv
src/tinyqv_core.sv
src/tinyqv_exec_top.sv
bench/tb_exec_top.sv

// File: run.sh
#!/bin/sh
# Build and run the execute subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f list.f --top-module tb_exec_top \
    -Mdir obj_dir -o tb_exec_top

# The log decides pass or fail
./obj_dir/tb_exec_top > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
